//--- compile.f
+incdir+sim
verilog/mips_ex_pkg.sv
verilog/alu_control.sv
verilog/ex_operand_sel.sv
verilog/mips_alu.sv
verilog/ex_stage.sv
sim/tb_ex_stage.sv

//--- Makefile
BIN := obj_dir/Vtb_ex_stage

.PHONY: all run clean

all: run

$(BIN): compile.f $(wildcard verilog/*.sv sim/*.sv sim/*.svh)
	verilator --binary --timing -j 0 --top-module tb_ex_stage -f compile.f

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -qx "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim/ex_model.svh
`ifndef EX_MODEL_SVH
`define EX_MODEL_SVH

  function automatic logic [31:0] rotate_right(input logic [31:0] v, input logic [4:0] n);
    return (v >> n) | (v << (32 - int'(n)));   // A zero count shifts the upper part out
  endfunction

  // Expected stage response from the MIPS decode and ALU rules
  function automatic ex_resp_t model_ex(input ex_req_t q);
    ex_resp_t    e;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sx;
    logic [31:0] r;
    logic [5:0]  fn;
    logic [4:0]  rf;
    logic [4:0]  sa;
    e  = '0;
    a  = q.rs_val;
    b  = q.rt_val;
    fn = q.instr[5:0];
    rf = q.instr[25:21];
    sa = q.instr[10:6];
    sx = {{16{q.instr[15]}}, q.instr[15:0]};
    r  = sx << a[4:0];   // Code 0 shifts the extended immediate
    case (q.instr[31:26])
      OP_RTYPE:
      begin
        case (fn)
          F_ADD, F_ADDU: r = a + b;
          F_SUB, F_SUBU: r = a - b;
          F_AND:  r = a & b;
          F_OR:   r = a | b;
          F_XOR:  r = a ^ b;
          F_NOR:  r = ~(a | b);
          F_SLT:  r = {31'h0, $signed(a) < $signed(b)};
          F_SLTU: r = {31'h0, a < b};
          F_SLL:  r = b << sa;
          F_SRL:  r = rf[0] ? rotate_right(b, sa) : b >> sa;
          F_SRA:  r = $signed(b) >>> sa;
          F_SLLV: r = b << a[4:0];
          F_SRLV: r = rf[0] ? rotate_right(b, a[4:0]) : b >> a[4:0];
          F_SRAV: r = $signed(b) >>> a[4:0];
          F_JR:   r = a;
          default:
          begin
            r         = b << a[4:0];
            e.unknown = 1'b1;
          end
        endcase
        e.jr  = (fn == F_JR);
        e.nop = (fn == F_SLL);   // Every SLL counts as NOP
      end
      OP_ADDI, OP_ADDIU, OP_LW, OP_SW: r = a + sx;
      OP_BEQ, OP_BNE: r = a - b;
      OP_ANDI: r = a & {16'h0, q.instr[15:0]};
      OP_ORI:  r = a | {16'h0, q.instr[15:0]};
      OP_XORI: r = a ^ {16'h0, q.instr[15:0]};
      OP_LUI:  r = {q.instr[15:0], 16'h0};
      OP_COP0:
      begin
        e.eret    = rf[4] && (fn == F_ERET);
        e.unknown = rf[4] && (fn != F_ERET);
        e.mfc0    = (rf == 5'd0);
        e.mtc0    = (rf == 5'd4);
      end
      default: ;
    endcase
    e.result = r;
    e.zero   = (r == '0);
    return e;
  endfunction

`endif

//--- sim/tb_ex_stage.sv
`default_nettype none

module tb_ex_stage;

  import mips_ex_pkg::*;

  `include "ex_model.svh"

  localparam int N_PER_TEST = 40;
  localparam int N_TESTS    = 5;
  localparam int RST_CYCLES = 10;

  localparam alu_op_t ALU_FUNCS [10] = '{F_ADD, F_ADDU, F_SUB, F_SUBU, F_AND, F_OR, F_XOR,
                                         F_NOR, F_SLT, F_SLTU};
  localparam alu_op_t SHIFT_FUNCS [6] = '{F_SLL, F_SRL, F_SRA, F_SLLV, F_SRLV, F_SRAV};
  localparam logic [5:0] IMM_OPS [10] = '{OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI,
                                          OP_LUI, OP_LW, OP_SW, OP_BEQ, OP_BNE};

  logic     clk;
  logic     rst_n;
  logic     req_valid;
  logic     rsp_valid;
  ex_req_t  req;
  ex_resp_t rsp;
  integer   seed = 87068;
  int       errors = 0;
  int       n_sent = 0;
  int       n_seen = 0;
  ex_resp_t exp_q [$];
  ex_resp_t exp_r;
  ex_resp_t last_rsp = '0;

  ex_stage ex_stage_inst (
    .i_clk   (clk),
    .i_rst_n (rst_n),
    .i_valid (req_valid),
    .i_req   (req),
    .o_valid (rsp_valid),
    .o_resp  (rsp)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial
  begin
    #((N_TESTS * N_PER_TEST * 3 + RST_CYCLES) * 100);
    $display("Timeout at %0t: the DUT stopped returning results", $time);
    $display("Test FAILED");
    $finish;
  end

  function automatic int pick(input int n);
    return int'({$random(seed)} % n);
  endfunction

  function automatic ex_req_t make_req(input int kind);
    ex_req_t    r;
    logic [5:0] opc;
    logic [5:0] fn;
    logic [4:0] rf;
    int         sel;
    r   = {$random(seed), $random(seed), $random(seed)};
    opc = OP_RTYPE;
    fn  = r.instr[5:0];
    rf  = r.instr[25:21];
    sel = pick(6);
    case (kind)
      0: fn = (sel == 0) ? fn : ALU_FUNCS[pick(10)];   // Raw codes reach the unknown path
      1: fn = SHIFT_FUNCS[sel];
      2: opc = IMM_OPS[pick(10)];
      default:
      begin
        opc = (sel < 2) ? OP_RTYPE : ((sel == 5) ? OP_J : OP_COP0);
        case (sel)
          0: fn = F_JR;
          1: fn = F_NOP;
          2:
          begin
            rf[4] = 1'b1;
            fn    = (pick(2) == 0) ? F_ERET : fn;
          end
          3: rf = (pick(2) == 0) ? 5'd0 : 5'd4;
          default: ;
        endcase
      end
    endcase
    if ((opc == OP_BEQ || opc == OP_BNE) && pick(2) == 0)
      r.rt_val = r.rs_val;   // Equal operands for the zero flag
    r.instr = {opc, rf, r.instr[20:6], fn};
    return r;
  endfunction

  task automatic mismatch(input string field, input logic [31:0] got, input logic [31:0] exp);
    $display("** Error at %0t: %s is %h, expected %h", $time, field, got, exp);
    errors++;
  endtask

  always @(negedge clk)
  begin
    if (rsp_valid)
    begin
      n_seen++;
      exp_r = exp_q.pop_front();
      if (rsp.result !== exp_r.result) mismatch("result", rsp.result, exp_r.result);
      if (rsp.zero !== exp_r.zero) mismatch("zero", 32'(rsp.zero), 32'(exp_r.zero));
      if (rsp.jr !== exp_r.jr) mismatch("jr", 32'(rsp.jr), 32'(exp_r.jr));
      if (rsp.nop !== exp_r.nop) mismatch("nop", 32'(rsp.nop), 32'(exp_r.nop));
      if (rsp.unknown !== exp_r.unknown)
        mismatch("unknown", 32'(rsp.unknown), 32'(exp_r.unknown));
      if (rsp.eret !== exp_r.eret) mismatch("eret", 32'(rsp.eret), 32'(exp_r.eret));
      if (rsp.mfc0 !== exp_r.mfc0) mismatch("mfc0", 32'(rsp.mfc0), 32'(exp_r.mfc0));
      if (rsp.mtc0 !== exp_r.mtc0) mismatch("mtc0", 32'(rsp.mtc0), 32'(exp_r.mtc0));
      last_rsp = rsp;
    end
    else if (rsp !== last_rsp)
    begin
      $display("** Error at %0t: o_resp changed while o_valid was low", $time);
      errors++;
    end
  end

  task automatic run_test(input string name, input int kind);
    int err_start;
    err_start = errors;
    repeat (N_PER_TEST)
    begin
      req       = make_req((kind == 4) ? pick(4) : kind);
      req_valid = 1'b1;
      exp_q.push_back(model_ex(req));
      n_sent++;
      @(negedge clk);
      req_valid = 1'b0;
      if (rsp_valid !== 1'b1) mismatch("o_valid", 32'(rsp_valid), 32'd1);   // One cycle late
      if (pick(2) == 0)
        @(negedge clk);   // Idle gap
    end
    while (exp_q.size() != 0)
      @(negedge clk);
    @(negedge clk);
    if (n_seen != n_sent)
    begin
      $display("%s: %0d requests sent but %0d results returned", name, n_sent, n_seen);
      errors++;
    end
    $display("%s: %0d strobes, %0d errors", name, N_PER_TEST, errors - err_start);
  endtask

  initial
  begin
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    repeat (RST_CYCLES)
      @(negedge clk);
    if (rsp_valid !== 1'b0 || rsp !== '0) mismatch("reset state", 32'(rsp_valid), 32'd0);
    rst_n = 1'b1;
    run_test("reset_latency", 4);
    run_test("rtype_alu", 0);
    run_test("shift_rotate", 1);
    run_test("imm_branch", 2);
    run_test("flags_cop0", 3);
    $display("Done: %0d strobes, %0d results, %0d errors", n_sent, n_seen, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/ex_stage.sv
`default_nettype none

module ex_stage (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_valid,
  input  mips_ex_pkg::ex_req_t   i_req,
  output logic                   o_valid,
  output mips_ex_pkg::ex_resp_t  o_resp
);

  import mips_ex_pkg::*;

  ex_ctrl_t          ctrl;
  ex_resp_t          resp_d;
  logic [DATA_W-1:0] op_a;
  logic [DATA_W-1:0] op_b;
  logic [DATA_W-1:0] alu_result;
  logic              alu_zero;

  alu_control alu_control_inst (
    .i_opcode  (i_req.instr[31:26]),
    .i_func    (i_req.instr[5:0]),
    .i_r_field (i_req.instr[25:21]),
    .o_ctrl    (ctrl)
  );

  ex_operand_sel ex_operand_sel_inst (
    .i_req       (i_req),
    .i_src_shamt (ctrl.src_shamt),
    .o_op_a      (op_a),
    .o_op_b      (op_b)
  );

  mips_alu mips_alu_inst (
    .i_alu_op (ctrl.alu_op),
    .i_op_a   (op_a),
    .i_op_b   (op_b),
    .o_result (alu_result),
    .o_zero   (alu_zero)
  );

  assign resp_d = '{result:  alu_result,
                    zero:    alu_zero,
                    jr:      ctrl.jr,
                    nop:     ctrl.nop,
                    unknown: ctrl.unknown,
                    eret:    ctrl.eret,
                    mfc0:    ctrl.mfc0,
                    mtc0:    ctrl.mtc0};

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      o_valid <= 1'b0;
      o_resp  <= '0;
    end
    else
    begin
      o_valid <= i_valid;
      if (i_valid)
      begin
        o_resp <= resp_d;   // Held while idle
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/mips_alu.sv
`default_nettype none

module mips_alu (
  input  mips_ex_pkg::alu_op_t               i_alu_op,
  input  logic [mips_ex_pkg::DATA_W-1:0]     i_op_a,
  input  logic [mips_ex_pkg::DATA_W-1:0]     i_op_b,
  output logic [mips_ex_pkg::DATA_W-1:0]     o_result,
  output logic                               o_zero
);

  import mips_ex_pkg::*;

  logic [4:0]          sh;
  logic [2*DATA_W-1:0] rot_wide;
  logic                slt_s;
  logic                slt_u;

  assign sh       = i_op_a[4:0];
  assign rot_wide = {i_op_b, i_op_b} >> sh;   // Low word is b rotated right
  assign slt_s    = $signed(i_op_a) < $signed(i_op_b);
  assign slt_u    = i_op_a < i_op_b;

  always_comb
  begin
    case (i_alu_op)
      F_ADD,
      F_ADDU:   o_result = i_op_a + i_op_b;
      F_SUB,
      F_SUBU:   o_result = i_op_a - i_op_b;
      F_AND:    o_result = i_op_a & i_op_b;
      F_OR:     o_result = i_op_a | i_op_b;
      F_XOR:    o_result = i_op_a ^ i_op_b;
      F_NOR:    o_result = ~(i_op_a | i_op_b);
      F_SLT:    o_result = {{(DATA_W-1){1'b0}}, slt_s};
      F_SLTU:   o_result = {{(DATA_W-1){1'b0}}, slt_u};
      F_SRL,
      F_SRLV:   o_result = i_op_b >> sh;
      F_SRA,
      F_SRAV:   o_result = $signed(i_op_b) >>> sh;
      F_ROTR,
      F_ROTRV:  o_result = rot_wide[DATA_W-1:0];
      F_LUI:    o_result = {i_op_b[15:0], {(DATA_W-16){1'b0}}};
      F_JR:     o_result = i_op_a;   // Jump target from rs
      F_SLL,
      F_SLLV:   o_result = i_op_b << sh;
      default:  o_result = i_op_b << sh;   // Unlisted codes act as SLL
    endcase
  end

  assign o_zero = (o_result == '0);

endmodule

`default_nettype wire

//--- verilog/ex_operand_sel.sv
`default_nettype none

module ex_operand_sel (
  input  mips_ex_pkg::ex_req_t               i_req,
  input  logic                               i_src_shamt,
  output logic [mips_ex_pkg::DATA_W-1:0]     o_op_a,
  output logic [mips_ex_pkg::DATA_W-1:0]     o_op_b
);

  import mips_ex_pkg::*;

  logic [5:0]        opcode;
  logic [4:0]        shamt;
  logic [15:0]       imm;
  logic [DATA_W-1:0] imm_zext;
  logic [DATA_W-1:0] imm_sext;

  assign opcode   = i_req.instr[31:26];
  assign shamt    = i_req.instr[10:6];
  assign imm      = i_req.instr[15:0];
  assign imm_zext = {{(DATA_W-16){1'b0}}, imm};
  assign imm_sext = {{(DATA_W-16){imm[15]}}, imm};

  assign o_op_a = i_src_shamt ? {{(DATA_W-5){1'b0}}, shamt} : i_req.rs_val;

  always_comb
  begin
    case (opcode)
      OP_RTYPE,
      OP_BEQ,
      OP_BNE:
      begin
        o_op_b = i_req.rt_val;
      end
      OP_ANDI,
      OP_ORI,
      OP_XORI:
      begin
        o_op_b = imm_zext;   // Logic immediates
      end
      default:
      begin
        o_op_b = imm_sext;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/alu_control.sv
`default_nettype none

module alu_control (
  input  logic [5:0]             i_opcode,
  input  logic [5:0]             i_func,
  input  logic [4:0]             i_r_field,
  output mips_ex_pkg::ex_ctrl_t  o_ctrl
);

  import mips_ex_pkg::*;

  always_comb
  begin
    o_ctrl = '0;

    case (i_opcode)
      OP_ADDI,
      OP_ADDIU,
      OP_LW,
      OP_SW:    o_ctrl.alu_op = F_ADD;   // Address or sum
      OP_BEQ,
      OP_BNE:   o_ctrl.alu_op = F_SUB;   // Zero flag compares
      OP_LUI:   o_ctrl.alu_op = F_LUI;
      OP_ORI:   o_ctrl.alu_op = F_OR;
      OP_XORI:  o_ctrl.alu_op = F_XOR;
      OP_ANDI:  o_ctrl.alu_op = F_AND;
      OP_RTYPE:
      begin
        case (i_func)
          F_ADD, F_ADDU, F_SUB, F_SUBU,
          F_AND, F_OR, F_XOR, F_NOR,
          F_SLT, F_SLTU, F_SLLV, F_SRAV:
          begin
            o_ctrl.alu_op = i_func;
          end
          F_SRLV:
          begin
            // R-field bit 0 turns a logical right shift into a rotate
            if (i_r_field[0])
            begin
              o_ctrl.alu_op = F_ROTRV;
            end
            else
            begin
              o_ctrl.alu_op = F_SRLV;
            end
          end
          F_NOP:
          begin
            o_ctrl.alu_op    = F_SLL;   // Shares the SLL encoding
            o_ctrl.src_shamt = 1'b1;
            o_ctrl.nop       = 1'b1;
          end
          F_SRA:
          begin
            o_ctrl.alu_op    = F_SRA;
            o_ctrl.src_shamt = 1'b1;
          end
          F_SRL:
          begin
            if (i_r_field[0])
            begin
              o_ctrl.alu_op = F_ROTR;
            end
            else
            begin
              o_ctrl.alu_op = F_SRL;
            end
            o_ctrl.src_shamt = 1'b1;
          end
          F_JR:
          begin
            o_ctrl.alu_op = F_JR;
            o_ctrl.jr     = 1'b1;
          end
          default:
          begin
            o_ctrl.unknown = 1'b1;   // Code stays 0
          end
        endcase
      end
      OP_COP0:
      begin
        casez (i_r_field)
          5'b1????:
          begin
            if (i_func == F_ERET)
            begin
              o_ctrl.eret = 1'b1;
            end
            else
            begin
              o_ctrl.unknown = 1'b1;
            end
          end
          5'b00000: o_ctrl.mfc0 = 1'b1;
          5'b00100: o_ctrl.mtc0 = 1'b1;
          default:  o_ctrl.alu_op = '0;   // No flag raised
        endcase
      end
      default:  o_ctrl.alu_op = '0;   // J and others
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/mips_ex_pkg.sv
`default_nettype none

package mips_ex_pkg;

  localparam int DATA_W = 32;

  typedef logic [5:0] alu_op_t;

  // Major opcodes, instr[31:26]
  localparam logic [5:0] OP_RTYPE = 6'h00;
  localparam logic [5:0] OP_J     = 6'h02;
  localparam logic [5:0] OP_BEQ   = 6'h04;
  localparam logic [5:0] OP_BNE   = 6'h05;
  localparam logic [5:0] OP_ADDI  = 6'h08;
  localparam logic [5:0] OP_ADDIU = 6'h09;
  localparam logic [5:0] OP_ANDI  = 6'h0C;
  localparam logic [5:0] OP_ORI   = 6'h0D;
  localparam logic [5:0] OP_XORI  = 6'h0E;
  localparam logic [5:0] OP_LUI   = 6'h0F;
  localparam logic [5:0] OP_COP0  = 6'h10;
  localparam logic [5:0] OP_LW    = 6'h23;
  localparam logic [5:0] OP_SW    = 6'h2B;

  // Function codes, also used as ALU codes
  localparam alu_op_t F_SLL   = 6'b000000;
  localparam alu_op_t F_NOP   = 6'b000000;   // Same encoding as SLL
  localparam alu_op_t F_SRL   = 6'b000010;
  localparam alu_op_t F_SRA   = 6'b000011;
  localparam alu_op_t F_SLLV  = 6'b000100;
  localparam alu_op_t F_SRLV  = 6'b000110;
  localparam alu_op_t F_SRAV  = 6'b000111;
  localparam alu_op_t F_JR    = 6'b001000;
  localparam alu_op_t F_ERET  = 6'b011000;
  localparam alu_op_t F_ADD   = 6'b100000;
  localparam alu_op_t F_ADDU  = 6'b100001;
  localparam alu_op_t F_SUB   = 6'b100010;
  localparam alu_op_t F_SUBU  = 6'b100011;
  localparam alu_op_t F_AND   = 6'b100100;
  localparam alu_op_t F_OR    = 6'b100101;
  localparam alu_op_t F_XOR   = 6'b100110;
  localparam alu_op_t F_NOR   = 6'b100111;
  localparam alu_op_t F_SLT   = 6'b101010;
  localparam alu_op_t F_SLTU  = 6'b101011;
  localparam alu_op_t F_LUI   = 6'b111100;   // Internal only
  localparam alu_op_t F_ROTR  = 6'b111110;   // Internal only
  localparam alu_op_t F_ROTRV = 6'b111111;   // Internal only

  typedef struct packed {
    logic [31:0]       instr;
    logic [DATA_W-1:0] rs_val;
    logic [DATA_W-1:0] rt_val;
  } ex_req_t;

  typedef struct packed {
    alu_op_t alu_op;
    logic    src_shamt;   // Operand a from shamt field
    logic    jr;
    logic    nop;
    logic    unknown;
    logic    eret;
    logic    mfc0;
    logic    mtc0;
  } ex_ctrl_t;

  typedef struct packed {
    logic [DATA_W-1:0] result;
    logic              zero;
    logic              jr;
    logic              nop;
    logic              unknown;
    logic              eret;
    logic              mfc0;
    logic              mtc0;
  } ex_resp_t;

endpackage

`default_nettype wire
